/* tb.f */
hw/icache_pkg.sv
hw/icache_tag_store.sv
hw/icache_data_ways.sv
hw/icache_ctrl.sv
hw/icache_top.sv
testbench/icache_checker.sv
testbench/icache_tb.sv

/* Makefile */
# Verilator regression for the two-way instruction cache

TOP       ?= icache_tb
VERILATOR ?= verilator
FLAGS     ?= --x-assign unique --x-initial unique
OBJ_DIR   ?= obj_dir
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "Variables: TOP VERILATOR FLAGS OBJ_DIR"

test:
	$(VERILATOR) --binary --timing --assert $(FLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f tb.f
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/icache_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the two-way instruction cache. Models refill
// memory with random acknowledge delays, runs cold miss, hit,
// LRU replacement, invalidate and a random fetch sweep.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module icache_tb
   import icache_pkg::*;
();

   localparam logic [31:0] SEED    = 32'hb9fc_59c5;
   localparam logic [31:0] MEM_XOR = 32'h5a5a_0f0f;
   localparam int          TIMEOUT = 200;
   // Three lines of set 10 with tags 0x91, 0x92, 0x93
   localparam logic [31:0] LINE_A  = 32'h0001_2354;
   localparam logic [31:0] LINE_B  = 32'h0001_2548;
   localparam logic [31:0] LINE_C  = 32'h0001_274c;

   logic                  clk;
   logic                  rst_i;
   logic                  cpu_req_i;
   fetch_addr_t           cpu_adr_i;
   logic                  cpu_ack_o;
   logic [DATA_WIDTH-1:0] cpu_dat_o;
   ibus_req_t             ibus_o;
   logic                  ibus_ack_i = 1'b0;
   logic [DATA_WIDTH-1:0] ibus_dat_i = '0;
   spr_req_t              spr_i;
   logic                  spr_ack_o;
   // Memory model delay state
   logic [31:0]           delay_seed = SEED;
   logic [1:0]            delay_left = '0;
   // Bus words and request cycles seen by the last fetch
   logic [31:0]           seen_adr [$];
   int                    req_cycles;
   int                    latency;
   logic [31:0]           sweep_seed;
   int                    errors;
   int                    timeouts;

   icache_top u_icache_top (
      .clk        (clk),
      .rst_i      (rst_i),
      .cpu_req_i  (cpu_req_i),
      .cpu_adr_i  (cpu_adr_i),
      .cpu_ack_o  (cpu_ack_o),
      .cpu_dat_o  (cpu_dat_o),
      .ibus_o     (ibus_o),
      .ibus_ack_i (ibus_ack_i),
      .ibus_dat_i (ibus_dat_i),
      .spr_i      (spr_i),
      .spr_ack_o  (spr_ack_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Instruction memory contents
   function automatic logic [31:0] mem_word(input logic [31:0] adr);
      return {adr[31:2], 2'b00} ^ MEM_XOR;
   endfunction

   // Refill memory acks each word after 0 to 3 idle cycles
   always @(posedge clk) begin
      if (rst_i) begin
         ibus_ack_i <= 1'b0;
         delay_left <= 2'd0;
      end else if (ibus_ack_i) begin
         ibus_ack_i <= 1'b0;
      end else if (ibus_o.req) begin
         if (delay_left == 2'd0) begin
            ibus_ack_i <= 1'b1;
            ibus_dat_i <= mem_word(ibus_o.adr);
            delay_seed = lcg_next(delay_seed);
            delay_left <= delay_seed[17:16];
         end else begin
            delay_left <= delay_left - 2'd1;
         end
      end
   end

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act == exp) else begin
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   // Fetch held until cpu_ack_o and checked on the ack
   task automatic fetch_word(input string name, input logic [31:0] adr);
      int cycles;
      bit done;
      cycles     = 0;
      done       = 1'b0;
      req_cycles = 0;
      seen_adr.delete();
      @(posedge clk);
      cpu_req_i <= 1'b1;
      cpu_adr_i <= adr;
      while (!done && cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
         if (ibus_o.req) begin
            req_cycles++;
         end
         if (ibus_o.req && ibus_ack_i) begin
            seen_adr.push_back(ibus_o.adr);
         end
         if (cpu_ack_o) begin
            done = 1'b1;
            check_value({name, " data"}, mem_word(adr), cpu_dat_o);
         end
      end
      cpu_req_i <= 1'b0;
      // Cycles after the one that sampled the request
      latency = cycles - 1;
      if (!done) begin
         $display("Timeout: fetch %s at %h got no CPU acknowledge", name, adr);
         timeouts++;
      end
   endtask

   task automatic check_refill(input string name, input logic [31:0] adr);
      logic [31:0] exp_adr;
      check_value({name, " refill words"}, 32'd8, seen_adr.size());
      for (int i = 0; i < seen_adr.size(); i++) begin
         // Burst wraps inside the line from the missed word
         exp_adr = {adr[31:5], 5'b0} | ((((adr >> 2) + i) & 32'd7) << 2);
         check_value({name, " refill address"}, exp_adr, seen_adr[i]);
      end
   endtask

   task automatic check_hit(input string name);
      check_value({name, " bus cycles"}, 32'd0, req_cycles);
      check_value({name, " latency"}, 32'd1, latency);
   endtask

   // Block invalidate write and a short watch for a second pulse
   task automatic spr_invalidate(input string name, input logic [31:0] adr);
      int cycles;
      int pulses;
      cycles = 0;
      pulses = 0;
      @(posedge clk);
      spr_i <= '{stb: 1'b1, we: 1'b1, addr: SPR_ICBIR_ADDR, dat: adr};
      while (pulses == 0 && cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
         if (spr_ack_o) begin
            pulses++;
         end
      end
      spr_i <= '0;
      if (pulses == 0) begin
         $display("Timeout: invalidate %s at %h got no SPR acknowledge", name, adr);
         timeouts++;
      end else begin
         repeat (3) begin
            @(posedge clk);
            if (spr_ack_o) begin
               pulses++;
            end
         end
         check_value({name, " ack pulses"}, 32'd1, pulses);
      end
   endtask

   initial begin
      rst_i      = 1'b1;
      cpu_req_i  = 1'b0;
      cpu_adr_i  = '0;
      spr_i      = '0;
      errors     = 0;
      timeouts   = 0;
      sweep_seed = SEED;
      repeat (8) @(posedge clk);
      rst_i <= 1'b0;
      // Tag RAM powers up unknown
      for (int s = 0; s < NUM_SETS; s++) begin
         spr_invalidate("startup", 32'(s) << BLOCK_WIDTH);
      end
      fetch_word("cold miss", LINE_A);
      check_refill("cold miss", LINE_A);
      fetch_word("same line hit", {LINE_A[31:5], 5'b0});
      check_hit("same line hit");
      // Touching A after B makes B the victim of C
      fetch_word("miss B", LINE_B);
      check_refill("miss B", LINE_B);
      fetch_word("touch A", LINE_A);
      check_hit("touch A");
      fetch_word("miss C", LINE_C);
      check_refill("miss C", LINE_C);
      fetch_word("A kept", LINE_A);
      check_hit("A kept");
      fetch_word("B evicted", LINE_B);
      check_refill("B evicted", LINE_B);
      spr_invalidate("invalidate A", LINE_A);
      fetch_word("A after invalidate", LINE_A);
      check_refill("A after invalidate", LINE_A);
      // Eight tags per set give a mix of hits and misses
      for (int i = 0; i < 60; i++) begin
         sweep_seed = lcg_next(sweep_seed);
         fetch_word("sweep", sweep_seed & 32'h0000_0ffc);
         assert (seen_adr.size() == 0 || seen_adr.size() == 8) else begin
            $display("FAIL sweep refill words: expected 0 or 8, actual %0d",
                     seen_adr.size());
            errors++;
         end
      end
      $display("Summary: %0d check errors, %0d assertion failures, %0d timeouts",
               errors, u_icache_top.u_checker.fail_total, timeouts);
      if (errors == 0 && timeouts == 0 && u_icache_top.u_checker.fail_total == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* testbench/icache_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Port assertions for the instruction cache, bound into
// icache_top. Fetch data, refill address hold and the CPU
// and SPR acknowledge rules.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module icache_checker
   import icache_pkg::*;
(
   input logic                  clk,
   input logic                  rst_i,
   input fetch_addr_t           cpu_adr_i,
   input logic                  cpu_ack_o,
   input logic [DATA_WIDTH-1:0] cpu_dat_o,
   input ibus_req_t             ibus_o,
   input logic                  ibus_ack_i,
   input logic                  spr_ack_o
);

   logic [DATA_WIDTH-1:0] exp_dat;
   int unsigned           dat_fails = 0;
   int unsigned           adr_fails = 0;
   int unsigned           spr_fails = 0;
   int unsigned           ack_fails = 0;
   int unsigned           fail_total;

   // Memory word of the fetch address
   assign exp_dat    = {cpu_adr_i[ADDR_WIDTH-1:2], 2'b00} ^ 32'h5a5a_0f0f;
   assign fail_total = dat_fails + adr_fails + spr_fails + ack_fails;

   data_matches_memory: assert property (@(posedge clk) disable iff (rst_i)
      cpu_ack_o |-> cpu_dat_o == exp_dat)
      else begin
         $error("FAIL data_matches_memory: expected %h, actual %h",
                $sampled(exp_dat), $sampled(cpu_dat_o));
         dat_fails++;
      end

   // Address only moves after an acknowledge
   bus_adr_held: assert property (@(posedge clk) disable iff (rst_i)
      ibus_o.req && !ibus_ack_i |=> ibus_o.req && $stable(ibus_o.adr))
      else begin
         $error("Refill request dropped or address moved without an acknowledge");
         adr_fails++;
      end

   spr_ack_single: assert property (@(posedge clk) disable iff (rst_i)
      spr_ack_o |=> !spr_ack_o)
      else begin
         $error("SPR acknowledge stayed high for two cycles");
         spr_fails++;
      end

   no_ack_during_refill: assert property (@(posedge clk) disable iff (rst_i)
      !(cpu_ack_o && ibus_o.req))
      else begin
         $error("CPU acknowledge while a refill request is active");
         ack_fails++;
      end

endmodule

bind icache_top icache_checker u_checker (
   .clk        (clk),
   .rst_i      (rst_i),
   .cpu_adr_i  (cpu_adr_i),
   .cpu_ack_o  (cpu_ack_o),
   .cpu_dat_o  (cpu_dat_o),
   .ibus_o     (ibus_o),
   .ibus_ack_i (ibus_ack_i),
   .spr_ack_o  (spr_ack_o)
);

/* hw/icache_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-way set-associative instruction cache top level.
// Connects CPU fetch port, refill bus and SPR invalidate
// port to the tag store, controller and data ways.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module icache_top
   import icache_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_i,
   // CPU fetch side
   input  logic                  cpu_req_i,
   input  fetch_addr_t           cpu_adr_i,
   output logic                  cpu_ack_o,
   output logic [DATA_WIDTH-1:0] cpu_dat_o,
   // Refill bus
   output ibus_req_t             ibus_o,
   input  logic                  ibus_ack_i,
   input  logic [DATA_WIDTH-1:0] ibus_dat_i,
   // SPR writes
   input  spr_req_t              spr_i,
   output logic                  spr_ack_o
);

   // Tag store results
   logic                      hit;
   logic                      hit_way;
   logic                      lru_way;
   // Controller commands
   tag_write_t                tag_wr;
   logic [SET_WIDTH-1:0]      tag_windex;
   logic [TAG_WIDTH-1:0]      refill_tag;
   logic [NUM_WAYS-1:0]       way_we;
   logic [WAY_ADDR_WIDTH-1:0] way_waddr;

   icache_tag_store u_tag_store (
      .clk          (clk),
      .cpu_adr_i    (cpu_adr_i),
      .tag_wr_i     (tag_wr),
      .tag_windex_i (tag_windex),
      .refill_tag_i (refill_tag),
      .hit_o        (hit),
      .hit_way_o    (hit_way),
      .lru_way_o    (lru_way)
   );

   icache_ctrl u_ctrl (
      .clk          (clk),
      .rst_i        (rst_i),
      .cpu_req_i    (cpu_req_i),
      .cpu_adr_i    (cpu_adr_i),
      .ibus_ack_i   (ibus_ack_i),
      .spr_i        (spr_i),
      .hit_i        (hit),
      .lru_way_i    (lru_way),
      .cpu_ack_o    (cpu_ack_o),
      .ibus_o       (ibus_o),
      .spr_ack_o    (spr_ack_o),
      .tag_wr_o     (tag_wr),
      .tag_windex_o (tag_windex),
      .refill_tag_o (refill_tag),
      .way_we_o     (way_we),
      .way_waddr_o  (way_waddr)
   );

   // Bus data feeds the ways directly
   icache_data_ways u_data_ways (
      .clk         (clk),
      .cpu_adr_i   (cpu_adr_i),
      .way_we_i    (way_we),
      .way_waddr_i (way_waddr),
      .ibus_dat_i  (ibus_dat_i),
      .hit_way_i   (hit_way),
      .cpu_dat_o   (cpu_dat_o)
   );

endmodule

/* hw/icache_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction cache controller. Runs lookup, wrapping line
// refill and block invalidate, and issues tag and data way
// write commands. Instantiated once by the cache top.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module icache_ctrl
   import icache_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_i,
   input  logic                      cpu_req_i,
   input  fetch_addr_t               cpu_adr_i,
   input  logic                      ibus_ack_i,
   input  spr_req_t                  spr_i,
   input  logic                      hit_i,
   input  logic                      lru_way_i,
   output logic                      cpu_ack_o,
   output ibus_req_t                 ibus_o,
   output logic                      spr_ack_o,
   output tag_write_t                tag_wr_o,
   output logic [SET_WIDTH-1:0]      tag_windex_o,
   output logic [TAG_WIDTH-1:0]      refill_tag_o,
   output logic [NUM_WAYS-1:0]       way_we_o,
   output logic [WAY_ADDR_WIDTH-1:0] way_waddr_o
);

   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      REFILL,
      INVALIDATE
   } state_e;

   state_e                    state_q;
   // Refill line address, word_sel wraps inside the line
   fetch_addr_t               refill_adr_q;
   // Acknowledged words of the current refill
   logic [WORD_SEL_WIDTH-1:0] ack_cnt_q;
   logic                      victim_q;
   logic [NUM_WAYS-1:0]       victim_oh;
   logic                      inv_wr;
   fetch_addr_t               inv_adr;
   logic                      refill_ack;
   logic                      first_ack;
   logic                      last_ack;

   // Block invalidate write decode
   assign inv_wr  = spr_i.stb && spr_i.we && (spr_i.addr == SPR_ICBIR_ADDR);
   assign inv_adr = fetch_addr_t'(spr_i.dat);

   assign victim_oh  = {victim_q, ~victim_q};
   assign refill_ack = (state_q == REFILL) && ibus_ack_i;
   assign first_ack  = refill_ack && (ack_cnt_q == '0);
   assign last_ack   = refill_ack &&
                       (ack_cnt_q == WORD_SEL_WIDTH'(WORDS_PER_LINE - 1));

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q   <= IDLE;
         ack_cnt_q <= '0;
         victim_q  <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               // SPR write wins over a pending fetch
               if (inv_wr) begin
                  state_q <= INVALIDATE;
               end else if (cpu_req_i) begin
                  state_q <= LOOKUP;
               end
            end
            LOOKUP: begin
               if (hit_i) begin
                  state_q <= IDLE;
               end else begin
                  // Miss, replace the least recently used way
                  victim_q  <= lru_way_i;
                  ack_cnt_q <= '0;
                  state_q   <= REFILL;
               end
            end
            REFILL: begin
               if (ibus_ack_i) begin
                  ack_cnt_q <= ack_cnt_q + 1'b1;
               end
               // Held request is looked up again from IDLE
               if (last_ack) begin
                  state_q <= IDLE;
               end
            end
            INVALIDATE: begin
               state_q <= IDLE;
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   // Refill address, burst starts at the missed word
   always_ff @(posedge clk) begin
      if (state_q == LOOKUP) begin
         refill_adr_q          <= cpu_adr_i;
         refill_adr_q.byte_sel <= '0;
      end else if (refill_ack) begin
         refill_adr_q.word_sel <= refill_adr_q.word_sel + 1'b1;
      end
   end

   // Tag write commands
   always_comb begin
      tag_wr_o = '{en: 1'b0, kind: TW_LRU_UPDATE, way: '0};
      case (state_q)
         LOOKUP: begin
            // LRU points away from the hit way
            tag_wr_o.en = hit_i;
         end
         REFILL: begin
            tag_wr_o.way = victim_oh;
            if (first_ack) begin
               // Victim line becomes invalid while it is overwritten
               tag_wr_o.en   = 1'b1;
               tag_wr_o.kind = TW_REFILL_START;
            end else if (last_ack) begin
               tag_wr_o.en   = 1'b1;
               tag_wr_o.kind = TW_REFILL_FINISH;
            end
         end
         INVALIDATE: begin
            tag_wr_o.en   = 1'b1;
            tag_wr_o.kind = TW_INVALIDATE;
         end
         default: begin
         end
      endcase
   end

   // Set written in the tag RAM
   always_comb begin
      case (state_q)
         INVALIDATE: tag_windex_o = inv_adr.set_idx;
         REFILL:     tag_windex_o = refill_adr_q.set_idx;
         default:    tag_windex_o = cpu_adr_i.set_idx;
      endcase
   end

   assign refill_tag_o = refill_adr_q.tag;

   // Each acknowledged word lands in the victim way
   assign way_we_o    = refill_ack ? victim_oh : '0;
   assign way_waddr_o = {refill_adr_q.set_idx, refill_adr_q.word_sel};

   assign ibus_o.req = (state_q == REFILL);
   assign ibus_o.adr = refill_adr_q;

   // Hit answers in the LOOKUP cycle
   assign cpu_ack_o = (state_q == LOOKUP) && hit_i;
   assign spr_ack_o = (state_q == INVALIDATE);

endmodule

/* hw/icache_data_ways.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data ways of the instruction cache. Two word RAMs read at
// the fetch address, filled from the refill bus, muxed by hit way.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module icache_data_ways
   import icache_pkg::*;
(
   input  logic                      clk,
   input  fetch_addr_t               cpu_adr_i,
   input  logic [NUM_WAYS-1:0]       way_we_i,
   input  logic [WAY_ADDR_WIDTH-1:0] way_waddr_i,
   input  logic [DATA_WIDTH-1:0]     ibus_dat_i,
   input  logic                      hit_way_i,
   output logic [DATA_WIDTH-1:0]     cpu_dat_o
);

   // Read index, set and word of the fetch
   logic [WAY_ADDR_WIDTH-1:0] raddr;

   assign raddr = {cpu_adr_i.set_idx, cpu_adr_i.word_sel};

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      logic [DATA_WIDTH-1:0] mem [WAY_WORDS];
      logic [DATA_WIDTH-1:0] dout_q;

      // Synchronous read, same timing as the tag RAM
      always_ff @(posedge clk) begin
         if (way_we_i[w]) begin
            mem[way_waddr_i] <= ibus_dat_i;
         end
         dout_q <= mem[raddr];
      end
   end

   // Hit way word to the CPU
   assign cpu_dat_o = hit_way_i ? g_way[1].dout_q : g_way[0].dout_q;

endmodule

/* hw/icache_tag_store.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag RAM of the instruction cache with per-way hit compare
// and one-bit LRU history. Read every cycle at the fetch set,
// written on controller command.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module icache_tag_store
   import icache_pkg::*;
(
   input  logic                 clk,
   input  fetch_addr_t          cpu_adr_i,
   input  tag_write_t           tag_wr_i,
   input  logic [SET_WIDTH-1:0] tag_windex_i,
   input  logic [TAG_WIDTH-1:0] refill_tag_i,
   output logic                 hit_o,
   output logic                 hit_way_o,
   output logic                 lru_way_o
);

   tag_entry_t          tag_ram [NUM_SETS];
   // Entry of the fetch set, one cycle after the read
   tag_entry_t          rd_entry_q;
   tag_entry_t          wr_entry;
   logic [NUM_WAYS-1:0] way_hit;

   always_ff @(posedge clk) begin
      rd_entry_q <= tag_ram[cpu_adr_i.set_idx];
      if (tag_wr_i.en) begin
         tag_ram[tag_windex_i] <= wr_entry;
      end
   end

   // Valid tag compare against the held fetch address
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         way_hit[w] = rd_entry_q.way[w].valid &&
                      (rd_entry_q.way[w].tag == cpu_adr_i.tag);
      end
   end

   assign hit_o     = |way_hit;
   assign hit_way_o = way_hit[1];
   // History bit is the way to replace
   assign lru_way_o = rd_entry_q.lru;

   // Write word built from the read entry
   always_comb begin
      wr_entry = rd_entry_q;
      case (tag_wr_i.kind)
         TW_LRU_UPDATE: begin
            wr_entry.lru = ~hit_way_o;
         end
         TW_REFILL_START: begin
            for (int w = 0; w < NUM_WAYS; w++) begin
               if (tag_wr_i.way[w]) begin
                  wr_entry.way[w].valid = 1'b0;
               end
            end
         end
         TW_REFILL_FINISH: begin
            for (int w = 0; w < NUM_WAYS; w++) begin
               if (tag_wr_i.way[w]) begin
                  wr_entry.way[w] = '{valid: 1'b1, tag: refill_tag_i};
               end
            end
            // Refilled way 0 leaves way 1 as LRU and vice versa
            wr_entry.lru = tag_wr_i.way[0];
         end
         TW_INVALIDATE: begin
            // Whole set cleared, both ways and history
            wr_entry = '0;
         end
         default: begin
         end
      endcase
   end

endmodule

/* hw/icache_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared geometry, address fields and bus structs for the
// two-way instruction cache. Every cache module imports it
// with a wildcard import in its header.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package icache_pkg;

   // Cache geometry, 16 sets of 32-byte lines
   localparam int ADDR_WIDTH     = 32;
   localparam int DATA_WIDTH     = 32;
   localparam int BLOCK_WIDTH    = 5;
   localparam int SET_WIDTH      = 4;
   localparam int WORD_SEL_WIDTH = 3;
   localparam int BYTE_SEL_WIDTH = BLOCK_WIDTH - WORD_SEL_WIDTH;
   localparam int TAG_WIDTH      = ADDR_WIDTH - SET_WIDTH - BLOCK_WIDTH;
   localparam int WORDS_PER_LINE = 1 << WORD_SEL_WIDTH;
   localparam int NUM_SETS       = 1 << SET_WIDTH;
   localparam int NUM_WAYS       = 2;
   // Word address inside one data way
   localparam int WAY_ADDR_WIDTH = SET_WIDTH + WORD_SEL_WIDTH;
   localparam int WAY_WORDS      = 1 << WAY_ADDR_WIDTH;

   // Block invalidate SPR number
   localparam logic [15:0] SPR_ICBIR_ADDR = 16'h2002;

   // Fetch address split, MSB first
   typedef struct packed {
      logic [TAG_WIDTH-1:0]      tag;
      logic [SET_WIDTH-1:0]      set_idx;
      logic [WORD_SEL_WIDTH-1:0] word_sel;
      logic [BYTE_SEL_WIDTH-1:0] byte_sel;
   } fetch_addr_t;

   // One way of a tag entry
   typedef struct packed {
      logic                 valid;
      logic [TAG_WIDTH-1:0] tag;
   } tag_way_t;

   // Full tag RAM word; lru names the way to replace next
   typedef struct packed {
      logic                       lru;
      tag_way_t [NUM_WAYS-1:0]    way;
   } tag_entry_t;

   typedef struct packed {
      logic                  req;
      logic [ADDR_WIDTH-1:0] adr;
   } ibus_req_t;

   typedef struct packed {
      logic                  stb;
      logic                  we;
      logic [15:0]           addr;
      logic [DATA_WIDTH-1:0] dat;
   } spr_req_t;

   typedef enum logic [1:0] {
      TW_LRU_UPDATE,
      TW_REFILL_START,
      TW_REFILL_FINISH,
      TW_INVALIDATE
   } tag_wkind_e;

   // Tag write command, way is a one-hot victim mask
   typedef struct packed {
      logic                en;
      tag_wkind_e          kind;
      logic [NUM_WAYS-1:0] way;
   } tag_write_t;

endpackage
